/* arp_pkg.sv */
package arp_pkg;

  typedef logic [31:0] ipv4_t;
  typedef logic [47:0] mac_t;

  // Table entry layout is {ipv4, mac}
  localparam int ENTRY_W = 80;

  typedef enum logic [15:0] {
    ARP_REQUEST = 16'd1,
    ARP_REPLY   = 16'd2
  } arp_oper_e;

  localparam logic [15:0] ARP_HTYPE_ETH  = 16'd1;      // Ethernet
  localparam logic [15:0] ARP_PTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  ARP_HLEN       = 8'd6;
  localparam logic [7:0]  ARP_PLEN       = 8'd4;

  localparam int ARP_PAYLOAD_BYTES = 28;

endpackage

/* arp_table_ram.sv */
`timescale 1ns/1ps

module arp_table_ram #(
  parameter int ADDR_W = 3
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [ADDR_W-1:0]           addr,
  input  logic                        we,
  input  logic [arp_pkg::ENTRY_W-1:0] wdata,
  output logic [arp_pkg::ENTRY_W-1:0] rdata,
  output logic                        rvalid_flag
);
  import arp_pkg::*;

  localparam int DEPTH = 1 << ADDR_W;

  logic [ENTRY_W-1:0] mem [DEPTH];
  logic [DEPTH-1:0]   valid;

  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];                // Old data on read during write
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid       <= '0;
      rvalid_flag <= 1'b0;
    end else begin
      if (we) begin
        valid[addr] <= 1'b1;
      end
      rvalid_flag <= valid[addr];
    end
  end

endmodule

/* arp_table_arbiter.sv */
`timescale 1ns/1ps

module arp_table_arbiter #(
  parameter int ADDR_W = 3
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        lrn_mem_req,
  input  logic [ADDR_W-1:0]           lrn_addr,
  input  logic                        lrn_we,
  input  logic [arp_pkg::ENTRY_W-1:0] lrn_wdata,
  input  logic                        res_mem_req,
  input  logic [ADDR_W-1:0]           res_addr,
  output logic                        lrn_gnt,
  output logic                        res_gnt,
  output logic [ADDR_W-1:0]           mem_addr,
  output logic                        mem_we,
  output logic [arp_pkg::ENTRY_W-1:0] mem_wdata
);

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_LRN,
    OWN_RES
  } owner_e;

  owner_e owner;

  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= OWN_NONE;
    end else begin
      case (owner)
        OWN_NONE: begin
          if (lrn_mem_req) begin
            owner <= OWN_LRN;          // Learner wins ties
          end else if (res_mem_req) begin
            owner <= OWN_RES;
          end
        end
        OWN_LRN: begin
          if (!lrn_mem_req) begin
            owner <= res_mem_req ? OWN_RES : OWN_NONE;
          end
        end
        OWN_RES: begin
          if (!res_mem_req) begin
            owner <= lrn_mem_req ? OWN_LRN : OWN_NONE;
          end
        end
        default: owner <= OWN_NONE;
      endcase
    end
  end

  assign lrn_gnt   = (owner == OWN_LRN);
  assign res_gnt   = (owner == OWN_RES);
  assign mem_addr  = (owner == OWN_LRN) ? lrn_addr : res_addr;
  assign mem_we    = (owner == OWN_LRN) && lrn_we;
  assign mem_wdata = lrn_wdata;        // Only the learner writes

endmodule

/* arp_learner.sv */
`timescale 1ns/1ps

module arp_learner #(
  parameter int ADDR_W = 3
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        learn_val,
  input  arp_pkg::ipv4_t              learn_ipv4,
  input  arp_pkg::mac_t               learn_mac,
  output logic                        lrn_mem_req,
  input  logic                        lrn_gnt,
  output logic [ADDR_W-1:0]           lrn_addr,
  output logic                        lrn_we,
  output logic [arp_pkg::ENTRY_W-1:0] lrn_wdata,
  input  logic [arp_pkg::ENTRY_W-1:0] mem_rdata,
  input  logic                        mem_rvalid_flag
);
  import arp_pkg::*;

  typedef enum logic [1:0] {
    L_IDLE,
    L_GNT,
    L_SCAN,
    L_WRITE
  } lrn_state_e;

  lrn_state_e        state;
  ipv4_t             lrn_ip;
  mac_t              lrn_mac;
  ipv4_t             ent_ip;
  logic [ADDR_W:0]   scan_cnt;         // MSB marks the last address issued
  logic              rd_vld;
  logic [ADDR_W-1:0] rd_idx;
  logic              found;
  logic [ADDR_W-1:0] found_idx;
  logic [ADDR_W-1:0] rr_ptr;
  logic              hit;

  assign ent_ip = mem_rdata[ENTRY_W-1 -: $bits(ipv4_t)];
  assign hit    = rd_vld && mem_rvalid_flag && (ent_ip == lrn_ip);

  assign lrn_mem_req = (state != L_IDLE);
  assign lrn_we      = (state == L_WRITE);
  assign lrn_wdata   = {lrn_ip, lrn_mac};
  assign lrn_addr    = (state == L_WRITE) ? (found ? found_idx : rr_ptr) :
                       scan_cnt[ADDR_W-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= L_IDLE;
      scan_cnt <= '0;
      rd_vld   <= 1'b0;
      found    <= 1'b0;
      rr_ptr   <= '0;
    end else begin
      case (state)
        L_IDLE: begin
          found <= 1'b0;
          if (learn_val) begin
            lrn_ip  <= learn_ipv4;
            lrn_mac <= learn_mac;
            state   <= L_GNT;
          end
        end
        L_GNT: begin
          scan_cnt <= '0;
          rd_vld   <= 1'b0;
          if (lrn_gnt) begin
            state <= L_SCAN;
          end
        end
        L_SCAN: begin
          if (!scan_cnt[ADDR_W]) begin
            scan_cnt <= scan_cnt + 1'b1;
          end
          rd_vld <= !scan_cnt[ADDR_W];
          rd_idx <= scan_cnt[ADDR_W-1:0];
          if (hit) begin
            found     <= 1'b1;
            found_idx <= rd_idx;
          end
          if (rd_vld && (rd_idx == '1)) begin
            state <= L_WRITE;          // Whole table compared
          end
        end
        L_WRITE: begin
          if (!found) begin
            rr_ptr <= rr_ptr + 1'b1;   // New slot evicts the oldest
          end
          state <= L_IDLE;
        end
        default: state <= L_IDLE;
      endcase
    end
  end

endmodule

/* arp_resolver.sv */
`timescale 1ns/1ps

module arp_resolver #(
  parameter int ADDR_W        = 3,
  parameter int TRIES         = 2,
  parameter int TIMEOUT_TICKS = 1000000
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        tbl_req,
  input  arp_pkg::ipv4_t              tbl_ipv4,
  output logic                        tbl_val,
  output arp_pkg::mac_t               tbl_mac,
  output logic                        tbl_err,
  output logic                        res_mem_req,
  input  logic                        res_gnt,
  output logic [ADDR_W-1:0]           res_addr,
  input  logic [arp_pkg::ENTRY_W-1:0] mem_rdata,
  input  logic                        mem_rvalid_flag,
  input  logic                        learn_val,
  input  arp_pkg::ipv4_t              learn_ipv4,
  input  arp_pkg::mac_t               learn_mac,
  output logic                        send_req,
  output arp_pkg::ipv4_t              req_ipv4,
  input  logic                        tx_busy
);
  import arp_pkg::*;

  localparam int TRY_W = (TRIES < 1) ? 1 : $clog2(TRIES + 1);
  localparam int TMO_W = $clog2(TIMEOUT_TICKS + 1);

  typedef enum logic [2:0] {
    R_IDLE,
    R_GNT,
    R_SCAN,
    R_SEND,
    R_WAIT
  } res_state_e;

  res_state_e        state;
  ipv4_t             tgt_ip;
  ipv4_t             ent_ip;
  mac_t              ent_mac;
  logic [ADDR_W:0]   scan_cnt;
  logic              rd_vld;
  logic [ADDR_W-1:0] rd_idx;
  logic [TMO_W-1:0]  tmo_cnt;
  logic [TRY_W-1:0]  tries;
  logic              hit;

  assign {ent_ip, ent_mac} = mem_rdata;
  assign hit = rd_vld && mem_rvalid_flag && (ent_ip == tgt_ip);

  assign res_mem_req = (state == R_GNT) || (state == R_SCAN);
  assign res_addr    = scan_cnt[ADDR_W-1:0];
  assign req_ipv4    = tgt_ip;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= R_IDLE;
      tbl_val  <= 1'b0;
      tbl_err  <= 1'b0;
      send_req <= 1'b0;
      scan_cnt <= '0;
      rd_vld   <= 1'b0;
      tmo_cnt  <= '0;
      tries    <= '0;
    end else begin
      tbl_val  <= 1'b0;
      tbl_err  <= 1'b0;
      send_req <= 1'b0;
      case (state)
        R_IDLE: begin
          if (tbl_req) begin
            tgt_ip <= tbl_ipv4;
            tries  <= '0;
            state  <= R_GNT;
          end
        end
        R_GNT: begin
          scan_cnt <= '0;
          rd_vld   <= 1'b0;
          if (res_gnt) begin
            state <= R_SCAN;
          end
        end
        R_SCAN: begin
          if (!scan_cnt[ADDR_W]) begin
            scan_cnt <= scan_cnt + 1'b1;
          end
          rd_vld <= !scan_cnt[ADDR_W];
          rd_idx <= scan_cnt[ADDR_W-1:0];
          if (hit) begin
            tbl_val <= 1'b1;
            tbl_mac <= ent_mac;
            state   <= R_IDLE;
          end else if (rd_vld && (rd_idx == '1)) begin
            state <= R_SEND;           // Miss, table released
          end
        end
        R_SEND: begin
          tmo_cnt <= '0;
          if (!tx_busy) begin
            send_req <= 1'b1;
            state    <= R_WAIT;
          end
        end
        R_WAIT: begin
          tmo_cnt <= tmo_cnt + 1'b1;
          if (learn_val && (learn_ipv4 == tgt_ip)) begin
            tbl_val <= 1'b1;
            tbl_mac <= learn_mac;
            state   <= R_IDLE;
          end else if (tmo_cnt == TMO_W'(TIMEOUT_TICKS - 1)) begin
            if (tries == TRY_W'(TRIES)) begin
              tbl_err <= 1'b1;         // Retries used up
              state   <= R_IDLE;
            end else begin
              tries <= tries + 1'b1;
              state <= R_SEND;
            end
          end
        end
        default: state <= R_IDLE;
      endcase
    end
  end

endmodule

/* arp_tx_framer.sv */
`timescale 1ns/1ps

module arp_tx_framer (
  input  logic           clk,
  input  logic           rst,
  input  logic           send_req,
  input  arp_pkg::ipv4_t req_ipv4,
  input  arp_pkg::mac_t  dev_mac,
  input  arp_pkg::ipv4_t dev_ipv4,
  output logic           tx_busy,
  output logic           tx_valid,
  output logic [7:0]     tx_data,
  output logic           tx_last
);
  import arp_pkg::*;

  localparam int CNT_W = $clog2(ARP_PAYLOAD_BYTES);

  logic                           active;
  logic [CNT_W-1:0]               byte_cnt;
  ipv4_t                          tgt_ip;
  logic [ARP_PAYLOAD_BYTES*8-1:0] frame;

  // Request payload, sent most significant byte first
  assign frame = {ARP_HTYPE_ETH, ARP_PTYPE_IPV4, ARP_HLEN, ARP_PLEN, ARP_REQUEST,
                  dev_mac, dev_ipv4, 48'h0, tgt_ip};

  assign tx_data  = frame[(ARP_PAYLOAD_BYTES - 1 - int'(byte_cnt)) * 8 +: 8];
  assign tx_valid = active;
  assign tx_busy  = active;
  assign tx_last  = active && (byte_cnt == CNT_W'(ARP_PAYLOAD_BYTES - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      active   <= 1'b0;
      byte_cnt <= '0;
    end else if (!active) begin
      if (send_req) begin
        active   <= 1'b1;
        byte_cnt <= '0;
        tgt_ip   <= req_ipv4;
      end
    end else if (tx_last) begin
      active <= 1'b0;
    end else begin
      byte_cnt <= byte_cnt + 1'b1;
    end
  end

endmodule

/* arp_cache_top.sv */
`timescale 1ns/1ps

module arp_cache_top #(
  parameter int ADDR_W        = 3,
  parameter int TRIES         = 2,
  parameter int TIMEOUT_TICKS = 1000000
) (
  input  logic           clk,
  input  logic           rst,
  input  arp_pkg::mac_t  dev_mac,
  input  arp_pkg::ipv4_t dev_ipv4,
  input  logic           learn_val,
  input  arp_pkg::ipv4_t learn_ipv4,
  input  arp_pkg::mac_t  learn_mac,
  input  logic           tbl_req,
  input  arp_pkg::ipv4_t tbl_ipv4,
  output logic           tbl_val,
  output arp_pkg::mac_t  tbl_mac,
  output logic           tbl_err,
  output logic           tx_valid,
  output logic [7:0]     tx_data,
  output logic           tx_last
);
  import arp_pkg::*;

  logic               lrn_mem_req;
  logic               lrn_gnt;
  logic [ADDR_W-1:0]  lrn_addr;
  logic               lrn_we;
  logic [ENTRY_W-1:0] lrn_wdata;
  logic               res_mem_req;
  logic               res_gnt;
  logic [ADDR_W-1:0]  res_addr;
  logic [ADDR_W-1:0]  mem_addr;
  logic               mem_we;
  logic [ENTRY_W-1:0] mem_wdata;
  logic [ENTRY_W-1:0] mem_rdata;
  logic               mem_rvalid_flag;
  logic               send_req;
  ipv4_t              req_ipv4;
  logic               tx_busy;

  arp_table_ram #(.ADDR_W(ADDR_W)) i_arp_table_ram (
    .clk(clk), .rst(rst), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata),
    .rdata(mem_rdata), .rvalid_flag(mem_rvalid_flag)
  );

  arp_table_arbiter #(.ADDR_W(ADDR_W)) i_arp_table_arbiter (
    .clk(clk), .rst(rst),
    .lrn_mem_req(lrn_mem_req), .lrn_addr(lrn_addr), .lrn_we(lrn_we), .lrn_wdata(lrn_wdata),
    .res_mem_req(res_mem_req), .res_addr(res_addr),
    .lrn_gnt(lrn_gnt), .res_gnt(res_gnt),
    .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata)
  );

  arp_learner #(.ADDR_W(ADDR_W)) i_arp_learner (
    .clk(clk), .rst(rst),
    .learn_val(learn_val), .learn_ipv4(learn_ipv4), .learn_mac(learn_mac),
    .lrn_mem_req(lrn_mem_req), .lrn_gnt(lrn_gnt),
    .lrn_addr(lrn_addr), .lrn_we(lrn_we), .lrn_wdata(lrn_wdata),
    .mem_rdata(mem_rdata), .mem_rvalid_flag(mem_rvalid_flag)
  );

  arp_resolver #(
    .ADDR_W(ADDR_W), .TRIES(TRIES), .TIMEOUT_TICKS(TIMEOUT_TICKS)
  ) i_arp_resolver (
    .clk(clk), .rst(rst),
    .tbl_req(tbl_req), .tbl_ipv4(tbl_ipv4),
    .tbl_val(tbl_val), .tbl_mac(tbl_mac), .tbl_err(tbl_err),
    .res_mem_req(res_mem_req), .res_gnt(res_gnt), .res_addr(res_addr),
    .mem_rdata(mem_rdata), .mem_rvalid_flag(mem_rvalid_flag),
    .learn_val(learn_val), .learn_ipv4(learn_ipv4), .learn_mac(learn_mac),
    .send_req(send_req), .req_ipv4(req_ipv4), .tx_busy(tx_busy)
  );

  arp_tx_framer i_arp_tx_framer (
    .clk(clk), .rst(rst),
    .send_req(send_req), .req_ipv4(req_ipv4),
    .dev_mac(dev_mac), .dev_ipv4(dev_ipv4),
    .tx_busy(tx_busy), .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last)
  );

endmodule

/* tb_arp_cache.sv */
`timescale 1ns/1ps

module tb_arp_cache;

  localparam int ADDR_W        = 2;
  localparam int TRIES         = 1;
  localparam int TIMEOUT_TICKS = 200;
  localparam int DEPTH         = 1 << ADDR_W;
  localparam int FRAME_BYTES   = 28;
  localparam int LEARN_GAP     = 3 * DEPTH + 10;
  localparam int LOOKUP_LIMIT  = (TRIES + 1) * (TIMEOUT_TICKS + FRAME_BYTES) + 8 * DEPTH + 50;
  localparam int MAX_CYCLES    = 20000;    // Two no-reply misses dominate the six tests

  localparam logic [47:0] DEV_MAC  = 48'h02_00_5e_10_20_30;
  localparam logic [31:0] DEV_IPV4 = 32'hc0a8_0001;
  localparam logic [31:0] IP_A     = 32'hc0a8_0010;
  localparam logic [31:0] IP_B     = 32'hc0a8_0011;
  localparam logic [31:0] IP_C     = 32'hc0a8_0012;
  localparam logic [31:0] IP_D     = 32'hc0a8_0020;
  localparam logic [31:0] IP_E     = 32'hc0a8_0030;
  localparam logic [31:0] IP_EVICT = 32'h0a00_0100;

  logic        clk = 1'b0;
  logic        rst;
  logic        learn_val;
  logic [31:0] learn_ipv4;
  logic [47:0] learn_mac;
  logic        tbl_req;
  logic [31:0] tbl_ipv4;
  logic        tbl_val;
  logic [47:0] tbl_mac;
  logic        tbl_err;
  logic        tx_valid;
  logic [7:0]  tx_data;
  logic        tx_last;

  // Reference model of the table
  logic [31:0] model_ip  [DEPTH];
  logic [47:0] model_mac [DEPTH];
  logic        model_vld [DEPTH];
  int          model_ptr;

  logic [31:0] rng = 32'h4289;
  int          cycles = 0;
  int          err_count;
  int          tests_pass;
  int          tests_fail;

  arp_cache_top #(
    .ADDR_W(ADDR_W), .TRIES(TRIES), .TIMEOUT_TICKS(TIMEOUT_TICKS)
  ) i_arp_cache_top (
    .clk(clk), .rst(rst), .dev_mac(DEV_MAC), .dev_ipv4(DEV_IPV4),
    .learn_val(learn_val), .learn_ipv4(learn_ipv4), .learn_mac(learn_mac),
    .tbl_req(tbl_req), .tbl_ipv4(tbl_ipv4),
    .tbl_val(tbl_val), .tbl_mac(tbl_mac), .tbl_err(tbl_err),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run stopped at the cycle limit of %0d", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic logic [47:0] rand_mac();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[15:0], lo};
  endfunction

  // ARP request payload byte with the most significant field first
  function automatic logic [7:0] frame_byte(input int idx, input logic [31:0] tgt);
    logic [FRAME_BYTES*8-1:0] f;
    f = {16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0001, DEV_MAC, DEV_IPV4, 48'h0, tgt};
    return f[(FRAME_BYTES - 1 - idx) * 8 +: 8];
  endfunction

  function automatic int model_find(input logic [31:0] ip);
    int i;
    for (i = 0; i < DEPTH; i++) begin
      if (model_vld[i] && (model_ip[i] == ip)) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic void model_learn(input logic [31:0] ip, input logic [47:0] mac);
    int idx;
    idx = model_find(ip);
    if (idx < 0) begin
      idx       = model_ptr;               // Oldest slot goes
      model_ptr = (model_ptr + 1) % DEPTH;
    end
    model_ip[idx]  = ip;
    model_mac[idx] = mac;
    model_vld[idx] = 1'b1;
  endfunction

  task automatic report_mismatch(input string name, input logic [47:0] exp,
                                 input logic [47:0] act);
    $display("error %t %s expected %h actual %h", $time, name, exp, act);
    err_count++;
  endtask

  task automatic report_problem(input string what);
    $display("%t %s", $time, what);
    err_count++;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic learn(input logic [31:0] ip, input logic [47:0] mac);
    learn_val  = 1'b1;
    learn_ipv4 = ip;
    learn_mac  = mac;
    step();
    learn_val = 1'b0;
    model_learn(ip, mac);
    repeat (LEARN_GAP) step();
  endtask

  // Model decides between a hit, a miss answered by reply_mac and a miss with no reply
  task automatic lookup(input logic [31:0] ip, input bit reply, input logic [47:0] reply_mac);
    int          idx;
    int          n;
    int          byte_idx;
    int          frames;
    int          exp_frames;
    bit          got_val;
    bit          got_err;
    bit          replied;
    bit          stray;
    logic [47:0] exp_mac;
    logic [7:0]  exp_byte;
    idx        = model_find(ip);
    n          = 0;
    byte_idx   = 0;
    frames     = 0;
    got_val    = 1'b0;
    got_err    = 1'b0;
    replied    = 1'b0;
    stray      = 1'b0;
    exp_mac    = (idx >= 0) ? model_mac[idx] : reply_mac;
    exp_frames = (idx >= 0) ? 0 : (reply ? 1 : TRIES + 1);
    tbl_ipv4   = ip;
    tbl_req    = 1'b1;
    while (!got_val && !got_err && (n < LOOKUP_LIMIT)) begin
      step();
      n++;
      tbl_req   = 1'b0;
      learn_val = 1'b0;
      if (tx_valid) begin
        if (byte_idx >= FRAME_BYTES) begin
          report_problem("request frame runs past 28 bytes");
        end else begin
          exp_byte = frame_byte(byte_idx, ip);
          if (tx_data !== exp_byte) report_mismatch("tx_data", 48'(exp_byte), 48'(tx_data));
        end
        if (tx_last !== (byte_idx == FRAME_BYTES - 1)) begin
          report_mismatch("tx_last", 48'(byte_idx == FRAME_BYTES - 1), 48'(tx_last));
        end
        byte_idx++;
        if (tx_last) begin
          frames++;
          byte_idx = 0;
          if (reply && !replied) begin
            learn_val  = 1'b1;                 // Reply arrives after the request
            learn_ipv4 = ip;
            learn_mac  = reply_mac;
            replied    = 1'b1;
          end
        end
      end
      got_val = tbl_val;
      got_err = tbl_err;
    end
    if (!got_val && !got_err) begin
      report_problem($sformatf("lookup of %h gave no result in %0d cycles", ip, n));
    end else if (got_val && got_err) begin
      report_problem($sformatf("lookup of %h pulsed tbl_val and tbl_err together", ip));
    end else if ((idx >= 0) || reply) begin
      if (!got_val) begin
        report_problem($sformatf("lookup of %h failed where a MAC was expected", ip));
      end else if (tbl_mac !== exp_mac) begin
        report_mismatch("tbl_mac", exp_mac, tbl_mac);
      end
    end else if (!got_err) begin
      report_problem($sformatf("lookup of %h returned a MAC where tbl_err was expected", ip));
    end
    if (frames != exp_frames) report_mismatch("frame count", 48'(exp_frames), 48'(frames));
    if (replied) model_learn(ip, reply_mac);
    repeat (LEARN_GAP) begin
      step();
      if (!stray && ((tx_valid !== 1'b0) || (tbl_val !== 1'b0) || (tbl_err !== 1'b0))) begin
        report_problem($sformatf("lookup of %h kept sending bytes or results after it ended",
                                 ip));
        stray = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    if (err_count == errs_before) begin
      tests_pass++;
      $display("%s: passed", name);
    end else begin
      tests_fail++;
      $display("%s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  task automatic test_reset_idle();
    int errs;
    errs = err_count;
    repeat (10) begin
      if (tbl_val !== 1'b0) report_mismatch("tbl_val", 48'(0), 48'(tbl_val));
      if (tbl_err !== 1'b0) report_mismatch("tbl_err", 48'(0), 48'(tbl_err));
      if (tx_valid !== 1'b0) report_mismatch("tx_valid", 48'(0), 48'(tx_valid));
      step();
    end
    lookup(32'h0a00_0001, 1'b0, '0);         // Empty table sends requests
    finish_test("reset_idle", errs);
  endtask

  task automatic test_learn_hit();
    int errs;
    errs = err_count;
    learn(IP_A, rand_mac());
    lookup(IP_A, 1'b0, '0);
    finish_test("learn_hit", errs);
  endtask

  task automatic test_update_in_place();
    int errs;
    errs = err_count;
    learn(IP_B, rand_mac());
    learn(IP_C, rand_mac());
    learn(IP_A, rand_mac());
    lookup(IP_A, 1'b0, '0);
    lookup(IP_B, 1'b0, '0);
    lookup(IP_C, 1'b0, '0);
    finish_test("update_in_place", errs);
  endtask

  task automatic test_miss_reply();
    int errs;
    errs = err_count;
    lookup(IP_D, 1'b1, rand_mac());
    lookup(IP_D, 1'b0, '0);
    finish_test("miss_reply", errs);
  endtask

  task automatic test_miss_timeout();
    int errs;
    errs = err_count;
    lookup(IP_E, 1'b0, '0);
    finish_test("miss_timeout", errs);
  endtask

  task automatic test_evict();
    int errs;
    int i;
    errs = err_count;
    for (i = 0; i <= DEPTH; i++) begin
      learn(IP_EVICT + 32'(i), rand_mac());
    end
    for (i = 1; i <= DEPTH; i++) begin
      lookup(IP_EVICT + 32'(i), 1'b0, '0);
    end
    lookup(IP_EVICT, 1'b1, rand_mac());      // Evicted entry needs a request
    finish_test("evict_oldest", errs);
  endtask

  initial begin
    $timeformat(-9, 0, " ns", 0);
    rst        = 1'b1;
    learn_val  = 1'b0;
    learn_ipv4 = '0;
    learn_mac  = '0;
    tbl_req    = 1'b0;
    tbl_ipv4   = '0;
    err_count  = 0;
    tests_pass = 0;
    tests_fail = 0;
    model_ptr  = 0;
    for (int i = 0; i < DEPTH; i++) begin
      model_vld[i] = 1'b0;
      model_ip[i]  = '0;
      model_mac[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    test_reset_idle();
    test_learn_hit();
    test_update_in_place();
    test_miss_reply();
    test_miss_timeout();
    test_evict();
    $display("tests passed %0d failed %0d", tests_pass, tests_fail);
    if ((tests_fail == 0) && (err_count == 0)) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
arp_pkg.sv
arp_table_ram.sv
arp_table_arbiter.sv
arp_learner.sv
arp_resolver.sv
arp_tx_framer.sv
arp_cache_top.sv
tb_arp_cache.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_arp_cache
FILELIST   ?= all.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_TOP   ?= arp_cache_top
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) arp_pkg.sv arp_table_ram.sv arp_table_arbiter.sv \
	  arp_learner.sv arp_resolver.sv arp_tx_framer.sv arp_cache_top.sv --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
